/* hw/rv32i_types_pkg.sv */
`default_nettype none

package rv32i_types_pkg;

    typedef logic [31:0] word_t;    // Data word.
    typedef logic [4:0]  reg_idx_t; // Register index.

    // ########################################################################
    // Operation kinds issued to the back end
    // ########################################################################

    typedef enum logic [2:0] {
        op_addi,
        op_lui,
        op_jal,
        op_load,
        op_store
    } op_e;

    // Store widths reuse lb_mem, lh_mem and lw_mem.
    typedef enum logic [2:0] {
        lb_mem,
        lbu_mem,
        lh_mem,
        lhu_mem,
        lw_mem
    } load_op_e;

    // Write-back result source.
    typedef enum logic [3:0] {
        alu_out_wb,
        u_imm_wb,
        pc_plus4_wb,
        lb_wb,
        lbu_wb,
        lh_wb,
        lhu_wb,
        lw_wb
    } wb_sel_e;

endpackage

`default_nettype wire

/* hw/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Default word-address width, 256 words.
    localparam int unsigned DEF_ADDR_W = 8;

    typedef logic [DEF_ADDR_W-1:0] addr_t;      // Word address.
    typedef logic [3:0]            byte_mask_t; // One bit per lane.

    // ########################################################################
    // Arbiter ownership of the RAM
    // ########################################################################

    typedef enum logic [1:0] {
        arb_idle,
        arb_core,
        arb_host
    } arb_state_e;

endpackage

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import rv32i_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_s,
    input  reg_idx_t rs2_s,
    input  reg_idx_t rd_s,
    input  logic     rd_we,
    input  word_t    rd_v,
    output word_t    rs1_v,
    output word_t    rs2_v
);

    word_t regs [1:31]; // x0 is not stored.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_s != '0)) begin
            regs[rd_s] <= rd_v;
        end
    end

    // Old contents on a same-cycle write.
    assign rs1_v = (rs1_s == '0) ? '0 : regs[rs1_s];
    assign rs2_v = (rs2_s == '0) ? '0 : regs[rs2_s];

endmodule

`default_nettype wire

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv32i_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int unsigned ADDR_W = $bits(addr_t)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  op_e               op_kind,
    input  load_op_e          op_width,
    input  reg_idx_t          op_rd,
    input  reg_idx_t          op_rs1,
    input  reg_idx_t          op_rs2,
    input  word_t             op_imm,
    input  word_t             op_pc,
    output reg_idx_t          rs1_s,
    output reg_idx_t          rs2_s,
    input  word_t             rs1_v,
    input  word_t             rs2_v,
    output logic              core_req,
    output logic              core_we,
    output logic [ADDR_W-1:0] core_addr,
    output word_t             core_wdata,
    output byte_mask_t        core_wmask,
    input  logic              core_resp,
    output logic              busy,
    output logic              move_pipeline,
    output logic              wb_valid_in,
    output logic              wb_is_store,
    output wb_sel_e           wb_sel,
    output reg_idx_t          wb_rd_s_in,
    output word_t             alu_out,
    output word_t             u_imm,
    output word_t             pc,
    output logic [1:0]        mem_addr_lo
);

    word_t      sum;
    logic       is_mem;
    logic       is_mem_q;
    logic       req_q;
    word_t      st_data;
    byte_mask_t st_mask;
    wb_sel_e    sel;

    assign rs1_s  = op_rs1;
    assign rs2_s  = op_rs2;
    assign sum    = rs1_v + op_imm; // ADDI result and byte address.
    assign is_mem = (op_kind == op_load) || (op_kind == op_store);

    // ########################################################################
    // Store lanes and result select
    // ########################################################################

    always_comb begin
        case (op_width)
            lb_mem, lbu_mem: begin
                st_data = {4{rs2_v[7:0]}};
                st_mask = byte_mask_t'(4'b0001 << sum[1:0]);
            end
            lh_mem, lhu_mem: begin
                st_data = {2{rs2_v[15:0]}};
                st_mask = byte_mask_t'(4'b0011 << {sum[1], 1'b0});
            end
            default: begin
                st_data = rs2_v;
                st_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        case (op_kind)
            op_lui:  sel = u_imm_wb;
            op_jal:  sel = pc_plus4_wb;
            op_load: begin
                case (op_width)
                    lb_mem:  sel = lb_wb;
                    lbu_mem: sel = lbu_wb;
                    lh_mem:  sel = lh_wb;
                    lhu_mem: sel = lhu_wb;
                    default: sel = lw_wb;
                endcase
            end
            default: sel = alu_out_wb; // ADDI, and stores write nothing.
        endcase
    end

    // ########################################################################
    // mem_wb register and request level
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_in <= 1'b0;
            req_q       <= 1'b0;
        end else begin
            if (op_valid) begin
                wb_valid_in <= 1'b1;
            end else if (move_pipeline) begin
                wb_valid_in <= 1'b0;
            end
            if (op_valid && is_mem) begin
                req_q <= 1'b1;
            end else if (core_resp) begin
                req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            is_mem_q    <= is_mem;
            wb_is_store <= (op_kind == op_store);
            wb_sel      <= sel;
            wb_rd_s_in  <= op_rd;
            alu_out     <= sum;
            u_imm       <= op_imm;
            pc          <= op_pc;
            mem_addr_lo <= sum[1:0];
            core_we     <= (op_kind == op_store);
            core_addr   <= sum[ADDR_W+1:2];
            core_wdata  <= st_data;
            core_wmask  <= st_mask;
        end
    end

    assign core_req      = req_q;
    assign busy          = req_q; // Holds the issuer until the response.
    assign move_pipeline = wb_valid_in && (!is_mem_q || core_resp);

endmodule

`default_nettype wire

/* hw/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import rv32i_types_pkg::*;
(
    input  logic       wb_valid_in,
    input  logic       wb_is_store,
    input  logic       move_pipeline,
    input  wb_sel_e    wb_sel,
    input  reg_idx_t   wb_rd_s_in,
    input  word_t      alu_out,
    input  word_t      u_imm,
    input  word_t      pc,
    input  word_t      dmem_rdata,
    input  logic [1:0] mem_addr_lo,
    output logic       rd_we,
    output reg_idx_t   rd_s,
    output word_t      rd_v
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       lb_v;
    word_t       lbu_v;
    word_t       lh_v;
    word_t       lhu_v;

    // ########################################################################
    // Load lane extraction
    // ########################################################################

    assign ld_byte = dmem_rdata[8*mem_addr_lo +: 8];
    assign ld_half = dmem_rdata[16*mem_addr_lo[1] +: 16];

    assign lb_v  = {{24{ld_byte[7]}}, ld_byte};
    assign lbu_v = {24'b0, ld_byte};
    assign lh_v  = {{16{ld_half[15]}}, ld_half};
    assign lhu_v = {16'b0, ld_half};

    // ########################################################################
    // Result select
    // ########################################################################

    always_comb begin
        case (wb_sel)
            alu_out_wb:  rd_v = alu_out;
            u_imm_wb:    rd_v = u_imm;
            pc_plus4_wb: rd_v = pc + 32'd4;
            lb_wb:       rd_v = lb_v;
            lbu_wb:      rd_v = lbu_v;
            lh_wb:       rd_v = lh_v;
            lhu_wb:      rd_v = lhu_v;
            lw_wb:       rd_v = dmem_rdata;
            default:     rd_v = '0;
        endcase
    end

    assign rd_s  = wb_is_store ? '0 : wb_rd_s_in; // Stores target x0.
    assign rd_we = wb_valid_in && move_pipeline;

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import rv32i_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int unsigned ADDR_W = $bits(addr_t)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              core_req,
    input  logic              core_we,
    input  logic [ADDR_W-1:0] core_addr,
    input  word_t             core_wdata,
    input  byte_mask_t        core_wmask,
    output logic              core_resp,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  word_t             host_wdata,
    input  byte_mask_t        host_wmask,
    output logic              host_resp,
    output logic              ram_en,
    output logic              ram_we,
    output logic [ADDR_W-1:0] ram_addr,
    output word_t             ram_wdata,
    output byte_mask_t        ram_wmask,
    input  logic              ram_resp
);

    arb_state_e state_q;
    arb_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= arb_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        ram_en    = 1'b0;
        core_resp = 1'b0;
        host_resp = 1'b0;
        case (state_q)
            arb_idle: begin
                if (core_req) begin // Core wins a tie.
                    ram_en  = 1'b1;
                    state_d = arb_core;
                end else if (host_req) begin
                    ram_en  = 1'b1;
                    state_d = arb_host;
                end
            end
            arb_core: begin
                core_resp = ram_resp;
                if (ram_resp) begin
                    state_d = arb_idle;
                end
            end
            arb_host: begin
                host_resp = ram_resp;
                if (ram_resp) begin
                    state_d = arb_idle;
                end
            end
            default: state_d = arb_idle;
        endcase
    end

    // Only sampled with ram_en, which is raised in idle.
    assign ram_we    = core_req ? core_we    : host_we;
    assign ram_addr  = core_req ? core_addr  : host_addr;
    assign ram_wdata = core_req ? core_wdata : host_wdata;
    assign ram_wmask = core_req ? core_wmask : host_wmask;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import rv32i_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int unsigned ADDR_W = $bits(addr_t)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic [ADDR_W-1:0] ram_addr,
    input  word_t             ram_wdata,
    input  byte_mask_t        ram_wmask,
    output logic              ram_resp,
    output word_t             ram_rdata
);

    localparam int unsigned DEPTH = 2 ** ADDR_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (ram_wmask[i]) begin
                        mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
                    end
                end
            end
            ram_rdata <= mem[ram_addr]; // Old word on a write.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_resp <= 1'b0;
        end else begin
            ram_resp <= ram_en;
        end
    end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import rv32i_types_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int unsigned ADDR_W = $bits(addr_t)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  op_e               op_kind,
    input  load_op_e          op_width,
    input  reg_idx_t          op_rd,
    input  reg_idx_t          op_rs1,
    input  reg_idx_t          op_rs2,
    input  word_t             op_imm,
    input  word_t             op_pc,
    output logic              busy,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  word_t             host_wdata,
    input  byte_mask_t        host_wmask,
    output logic              host_resp,
    output word_t             host_rdata,
    output logic              retire_valid,
    output reg_idx_t          retire_rd,
    output word_t             retire_value
);

    // ########################################################################
    // Interconnect
    // ########################################################################

    reg_idx_t          rs1_s;
    reg_idx_t          rs2_s;
    word_t             rs1_v;
    word_t             rs2_v;
    logic              core_req;
    logic              core_we;
    logic [ADDR_W-1:0] core_addr;
    word_t             core_wdata;
    byte_mask_t        core_wmask;
    logic              core_resp;
    logic              move_pipeline;
    logic              wb_valid_in;
    logic              wb_is_store;
    wb_sel_e           wb_sel;
    reg_idx_t          wb_rd_s_in;
    word_t             alu_out;
    word_t             u_imm;
    word_t             pc;
    logic [1:0]        mem_addr_lo;
    logic              ram_en;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    word_t             ram_wdata;
    byte_mask_t        ram_wmask;
    logic              ram_resp;
    word_t             ram_rdata;

    assign host_rdata = ram_rdata; // Shared read bus.

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .rs1_s (rs1_s),
        .rs2_s (rs2_s),
        .rd_s  (retire_rd),
        .rd_we (retire_valid),
        .rd_v  (retire_value),
        .rs1_v (rs1_v),
        .rs2_v (rs2_v)
    );

    mem_stage #(
        .ADDR_W (ADDR_W)
    ) u_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .op_valid      (op_valid),
        .op_kind       (op_kind),
        .op_width      (op_width),
        .op_rd         (op_rd),
        .op_rs1        (op_rs1),
        .op_rs2        (op_rs2),
        .op_imm        (op_imm),
        .op_pc         (op_pc),
        .rs1_s         (rs1_s),
        .rs2_s         (rs2_s),
        .rs1_v         (rs1_v),
        .rs2_v         (rs2_v),
        .core_req      (core_req),
        .core_we       (core_we),
        .core_addr     (core_addr),
        .core_wdata    (core_wdata),
        .core_wmask    (core_wmask),
        .core_resp     (core_resp),
        .busy          (busy),
        .move_pipeline (move_pipeline),
        .wb_valid_in   (wb_valid_in),
        .wb_is_store   (wb_is_store),
        .wb_sel        (wb_sel),
        .wb_rd_s_in    (wb_rd_s_in),
        .alu_out       (alu_out),
        .u_imm         (u_imm),
        .pc            (pc),
        .mem_addr_lo   (mem_addr_lo)
    );

    wb_stage u_wb_stage (
        .wb_valid_in   (wb_valid_in),
        .wb_is_store   (wb_is_store),
        .move_pipeline (move_pipeline),
        .wb_sel        (wb_sel),
        .wb_rd_s_in    (wb_rd_s_in),
        .alu_out       (alu_out),
        .u_imm         (u_imm),
        .pc            (pc),
        .dmem_rdata    (ram_rdata),
        .mem_addr_lo   (mem_addr_lo),
        .rd_we         (retire_valid),
        .rd_s          (retire_rd),
        .rd_v          (retire_value)
    );

    mem_arbiter #(
        .ADDR_W (ADDR_W)
    ) u_mem_arbiter (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_we    (core_we),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_wmask (core_wmask),
        .core_resp  (core_resp),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_wmask (host_wmask),
        .host_resp  (host_resp),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_wmask  (ram_wmask),
        .ram_resp   (ram_resp)
    );

    data_ram #(
        .ADDR_W (ADDR_W)
    ) u_data_ram (
        .clk       (clk),
        .rst       (rst),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask),
        .ram_resp  (ram_resp),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* verification/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
    import rv32i_types_pkg::*;
    import mem_bus_pkg::*;
;
    localparam int ADDR_W = 8;
    localparam int LIMIT  = 50; // Cycles allowed per wait.

    logic              clk = 1'b0;
    logic              rst;
    logic              op_valid;
    op_e               op_kind;
    load_op_e          op_width;
    reg_idx_t          op_rd;
    reg_idx_t          op_rs1;
    reg_idx_t          op_rs2;
    word_t             op_imm;
    word_t             op_pc;
    logic              busy;
    logic              host_req;
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    word_t             host_wdata;
    byte_mask_t        host_wmask;
    logic              host_resp;
    word_t             host_rdata;
    logic              retire_valid;
    reg_idx_t          retire_rd;
    word_t             retire_value;

    word_t       regs_m [32]; // Register model.
    word_t       mem_m  [16]; // Words 0 to 15 of the RAM.
    int unsigned lcg_state = 83;

    lsu_top #(.ADDR_W(ADDR_W)) DUT (.*);

    always #10 clk = ~clk;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // ########################################################################
    // Compare tasks and reference rules
    // ########################################################################

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            stop_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic idx_match(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            stop_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic host_read_check(input word_t exp, input word_t act);
        if (exp !== act) begin
            stop_run($sformatf("[ERROR] host_rdata expected %h got %h", exp, act));
        end
    endtask

    function automatic word_t load_expect(word_t w, load_op_e width, logic [1:0] off);
        word_t sh;
        sh = w >> (8 * off);
        case (width)
            lb_mem:  return {{24{sh[7]}}, sh[7:0]};
            lbu_mem: return {24'h0, sh[7:0]};
            lh_mem:  return {{16{sh[15]}}, sh[15:0]};
            lhu_mem: return {16'h0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, byte_mask_t mask);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // ########################################################################
    // Drivers
    // ########################################################################

    task automatic issue_op(input op_e kind, input load_op_e width, input reg_idx_t rd,
                            input reg_idx_t rs1, input reg_idx_t rs2, input word_t imm,
                            input word_t pc);
        word_t      addr;
        word_t      exp;
        byte_mask_t mask;
        word_t      sdata;
        int         n;
        addr = regs_m[rs1] + imm;
        @(posedge clk);
        op_valid <= 1'b1;
        op_kind  <= kind;
        op_width <= width;
        op_rd    <= rd;
        op_rs1   <= rs1;
        op_rs2   <= rs2;
        op_imm   <= imm;
        op_pc    <= pc;
        @(posedge clk);
        op_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > LIMIT) stop_run("Timeout waiting for the core operation to retire.");
        end while (!retire_valid);
        if (kind != op_load && kind != op_store && n != 1) begin
            stop_run("A register operation did not retire in the cycle after issue.");
        end
        compare_word("busy", {31'h0, (kind == op_load || kind == op_store)}, {31'h0, busy});
        case (kind)
            op_addi: exp = addr;
            op_lui:  exp = imm;
            op_jal:  exp = pc + 32'd4;
            op_load: exp = load_expect(mem_m[addr[5:2]], width, addr[1:0]);
            default: exp = '0; // A store has no result value.
        endcase
        if (kind == op_store) begin
            sdata = regs_m[rs2] << (8 * addr[1:0]);
            case (width)
                lb_mem:  mask = 4'b0001 << addr[1:0];
                lh_mem:  mask = 4'b0011 << addr[1:0];
                default: mask = 4'b1111;
            endcase
            mem_m[addr[5:2]] = merge_bytes(mem_m[addr[5:2]], sdata, mask);
            idx_match("retire_rd", 5'd0, retire_rd);
        end else begin
            idx_match("retire_rd", rd, retire_rd);
            compare_word("retire_value", exp, retire_value);
            if (rd != 0) regs_m[rd] = exp;
        end
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > LIMIT) stop_run("Timeout waiting for busy to fall.");
        end
    endtask

    task automatic host_access(input logic we, input logic [3:0] widx, input word_t data,
                               input byte_mask_t mask);
        int n;
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= ADDR_W'(widx);
        host_wdata <= data;
        host_wmask <= mask;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > LIMIT) stop_run("Timeout waiting for the host response.");
        end while (!host_resp);
        if (we) begin
            mem_m[widx] = merge_bytes(mem_m[widx], data, mask);
        end else begin
            host_read_check(mem_m[widx], host_rdata);
        end
        @(posedge clk);
        host_req <= 1'b0;
    endtask

    // Random legal operation, with an optional host access racing it.
    task automatic random_step();
        int unsigned r;
        op_e         kind;
        load_op_e    width;
        logic [5:0]  baddr;
        int          dly;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       imm;
        word_t       pc;
        r     = next_rand();
        kind  = op_e'(r % 5);
        width = load_op_e'((r >> 4) % 5);
        baddr = 6'(next_rand());
        if (kind == op_store && width == lbu_mem) width = lb_mem;
        if (kind == op_store && width == lhu_mem) width = lh_mem;
        if (width == lh_mem || width == lhu_mem) baddr[0] = 1'b0;
        if (width == lw_mem) baddr[1:0] = 2'b00;
        if (kind != op_load && kind != op_store) width = lw_mem;
        dly = (r >> 8) % 3;
        rd  = reg_idx_t'(next_rand());
        rs1 = reg_idx_t'(next_rand());
        rs2 = reg_idx_t'(next_rand());
        if (kind == op_load || kind == op_store) rs1 = '0; // Address is the offset alone.
        case (kind)
            op_lui:  imm = word_t'(next_rand() << 12);
            op_addi: imm = word_t'($signed(12'(next_rand())));
            default: imm = word_t'(baddr);
        endcase
        pc = word_t'(next_rand() << 2);
        fork
            issue_op(kind, width, rd, rs1, rs2, imm, pc);
            if ((r >> 12) % 3 == 0) begin
                repeat (dly) @(posedge clk);
                host_access(next_rand() % 2, 4'(next_rand()), next_rand(), 4'(next_rand()));
            end
        join
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin
        rst        = 1'b1;
        op_valid   = 1'b0;
        op_kind    = op_addi;
        op_width   = lw_mem;
        op_rd      = '0;
        op_rs1     = '0;
        op_rs2     = '0;
        op_imm     = '0;
        op_pc      = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_wmask = '0;
        for (int i = 0; i < 32; i++) regs_m[i] = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_word("busy", 32'h0, {31'h0, busy});
        compare_word("retire_valid", 32'h0, {31'h0, retire_valid});
        compare_word("host_resp", 32'h0, {31'h0, host_resp});
        for (int i = 1; i < 32; i++) issue_op(op_addi, lw_mem, i, i, 0, 0, 0);

        for (int i = 0; i < 16; i++) begin
            host_access(1'b1, 4'(i), 32'hC3A50000 ^ (i * 32'h01030507), 4'hF);
        end

        // x0 stays zero.
        issue_op(op_addi, lw_mem, 0, 0, 0, 32'h123, 0);
        issue_op(op_addi, lw_mem, 1, 0, 0, 32'h7F5, 0);

        // Back-to-back register operations.
        @(posedge clk);
        op_valid <= 1'b1;
        op_kind  <= op_addi;
        op_rd    <= 5'd2;
        op_rs1   <= 5'd0;
        op_imm   <= 32'h55;
        @(posedge clk);
        op_kind  <= op_lui;
        op_rd    <= 5'd3;
        op_imm   <= 32'h8BADF000;
        @(negedge clk);
        compare_word("retire_valid", 32'h1, {31'h0, retire_valid});
        idx_match("retire_rd", 5'd2, retire_rd);
        compare_word("retire_value", 32'h55, retire_value);
        @(posedge clk);
        op_valid <= 1'b0;
        @(negedge clk);
        compare_word("retire_valid", 32'h1, {31'h0, retire_valid});
        idx_match("retire_rd", 5'd3, retire_rd);
        compare_word("retire_value", 32'h8BADF000, retire_value);
        @(negedge clk);
        compare_word("retire_valid", 32'h0, {31'h0, retire_valid});
        regs_m[2] = 32'h55;
        regs_m[3] = 32'h8BADF000;
        issue_op(op_addi, lw_mem, 3, 3, 0, 32'h00D, 0);

        // Every store width and offset, then every load variant.
        for (int w = 0; w < 3; w++) begin
            for (int off = 0; off < 4; off++) begin
                if (w == 1 && off[0]) continue;
                if (w == 2 && off != 0) continue;
                issue_op(op_store, (w == 0) ? lb_mem : (w == 1) ? lh_mem : lw_mem,
                         9, 0, 3, 40 + off, 0);
                for (int l = 0; l < 5; l++) begin
                    for (int lo = 0; lo < 4; lo++) begin
                        if (l >= 2 && l <= 3 && lo[0]) continue;
                        if (l == 4 && lo != 0) continue;
                        issue_op(op_load, load_op_e'(l), 4, 0, 0, 40 + lo, 0);
                    end
                end
            end
        end

        // Host and core see each other's writes.
        host_access(1'b1, 4'd5, 32'h13579BDF, 4'hF);
        issue_op(op_load, lw_mem, 6, 0, 0, 20, 0);
        issue_op(op_store, lh_mem, 7, 0, 3, 26, 0);
        host_access(1'b0, 4'd6, 32'h0, 4'h0);

        for (int i = 0; i < 300; i++) random_step();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/rv32i_types_pkg.sv
hw/mem_bus_pkg.sv
hw/regfile.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_arbiter.sv
hw/data_ram.sv
hw/lsu_top.sv
verification/tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu_top

sources:
  - hw/rv32i_types_pkg.sv
  - hw/mem_bus_pkg.sv
  - hw/regfile.sv
  - hw/mem_stage.sv
  - hw/wb_stage.sv
  - hw/mem_arbiter.sv
  - hw/data_ram.sv
  - hw/lsu_top.sv
  - target: simulation
    files:
      - verification/tb_lsu_top.sv
